/* common/rename_pkg.sv */
// shared widths, index types and packet formats for the rename front end
// every rtl module imports this package inside its body
`default_nettype none

package rename_pkg;

    ////////////////////////////////////////////////////
    // sizes
    localparam int width     = 2;   // superscalar width
    localparam int ib_depth  = 8;   // instruction buffer entries
    localparam int arch_regs = 8;
    localparam int phys_regs = 16;
    localparam int rob_depth = 8;
    localparam int fl_depth  = phys_regs - arch_regs;   // free tags after reset

    typedef logic [1:0]                    count_t;     // 0 .. width
    typedef logic [2:0]                    arch_idx_t;
    typedef logic [3:0]                    phys_idx_t;
    typedef logic [31:0]                   addr_t;
    typedef logic [$clog2(ib_depth)-1:0]   ib_ptr_t;
    typedef logic [$clog2(fl_depth)-1:0]   fl_ptr_t;
    typedef logic [$clog2(rob_depth)-1:0]  rob_ptr_t;

    ////////////////////////////////////////////////////
    // instruction word, opcode[3] picks the format
    typedef struct packed {
        logic [3:0] opcode;
        arch_idx_t  dest;
        arch_idx_t  src1;
        arch_idx_t  src2;
        logic [2:0] pad;
    } r_form_t;

    typedef struct packed {
        logic [3:0] opcode;
        arch_idx_t  dest;
        arch_idx_t  src1;
        logic [5:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } inst_word_u;

    typedef struct packed {
        inst_word_u word;
        addr_t      pc;      // filled in by the buffer
    } inst_packet_t;

    typedef struct packed {
        logic       valid;
        arch_idx_t  dest;
        arch_idx_t  src1;
        arch_idx_t  src2;
        logic       uses_src2;   // clear for immediate form
        logic [5:0] imm;
    } decoded_packet_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        arch_idx_t dest;
        phys_idx_t t;        // new tag
        phys_idx_t t_old;    // tag freed on commit
        phys_idx_t t1;
        phys_idx_t t2;
        logic      uses_src2;
    } commit_packet_t;

endpackage

`default_nettype wire

/* logic/cpu_front.sv */
// top of the rename front end
// buffer -> dispatch -> free list / map table -> rob, retire feeds the free list
`default_nettype none

module cpu_front (
    input  logic                                             clock,
    input  logic                                             reset,
    input  rename_pkg::inst_packet_t   [rename_pkg::width-1:0] in_insts,  // word only
    input  rename_pkg::count_t                               num_input,
    input  logic                       [rename_pkg::width-1:0] complete_valid,
    input  rename_pkg::phys_idx_t      [rename_pkg::width-1:0] complete_t,
    output rename_pkg::commit_packet_t [rename_pkg::width-1:0] committed_insts,
    output logic [3:0]                                       ib_open,
    output rename_pkg::addr_t                                pc
);
    import rename_pkg::*;

    ////////////////////////////////////////////////////
    // stage wires
    inst_packet_t    [width-1:0] ib_insts;
    logic [3:0]                  ib_count;
    decoded_packet_t [width-1:0] dis_insts;
    addr_t           [width-1:0] dis_pc;
    count_t                      num_dis;
    phys_idx_t       [width-1:0] fl_regs;      // next free tags
    logic [3:0]                  fl_avail;
    phys_idx_t       [width-1:0] r1_p, r2_p, mt_t_old;
    logic [3:0]                  rob_open;
    count_t                      num_retired;
    phys_idx_t       [width-1:0] ret_t_old;    // back to the free list

    always_comb begin
        for (int i = 0; i < width; i++) ret_t_old[i] = committed_insts[i].t_old;
    end

    inst_buffer u_ib (.clock(clock), .reset(reset), .in_insts(in_insts),
        .num_input(num_input), .num_dispatch(num_dis), .ib_insts(ib_insts),
        .ib_count(ib_count), .open_entries(ib_open), .pc(pc));

    dispatch u_dis (.ib_insts(ib_insts), .ib_count(ib_count), .rob_open(rob_open),
        .fl_avail(fl_avail), .num_dispatch(num_dis), .out_insts(dis_insts),
        .out_pc(dis_pc));

    free_list u_fl (.clock(clock), .reset(reset), .rd_num(num_dis),
        .wr_num(num_retired), .wr_reg(ret_t_old), .rd_reg(fl_regs), .avail(fl_avail));

    map_table u_mt (.clock(clock), .reset(reset), .dis_insts(dis_insts),
        .free_reg(fl_regs), .r1_p(r1_p), .r2_p(r2_p), .t_old(mt_t_old));

    rob u_rob (
        .clock(clock), .reset(reset),
        .wr_insts(dis_insts), .wr_pc(dis_pc), .num_accept(num_dis),
        .t(fl_regs), .t_old(mt_t_old), .t1(r1_p), .t2(r2_p),
        .complete_valid(complete_valid), .complete_t(complete_t),
        .retiring(committed_insts),   // valid the cycle before the freeing edge
        .num_retired(num_retired),
        .open_entries(rob_open)
    );

endmodule

`default_nettype wire

/* logic/dispatch.sv */
// decode and dispatch count selection
// purely combinational, feeds the rename blocks and the rob in the same cycle
`default_nettype none

module dispatch (
    input  rename_pkg::inst_packet_t    [rename_pkg::width-1:0] ib_insts,
    input  logic [3:0]                                       ib_count,
    input  logic [3:0]                                       rob_open,
    input  logic [3:0]                                       fl_avail,
    output rename_pkg::count_t                               num_dispatch,
    output rename_pkg::decoded_packet_t [rename_pkg::width-1:0] out_insts,
    output rename_pkg::addr_t           [rename_pkg::width-1:0] out_pc
);
    import rename_pkg::*;

    logic [3:0] lim;

    // min of width, buffer fill, rob space and free tags
    always_comb begin
        lim = 4'(width);
        if (ib_count < lim) lim = ib_count;
        if (rob_open < lim) lim = rob_open;
        if (fl_avail < lim) lim = fl_avail;
        num_dispatch = count_t'(lim);
    end

    always_comb begin
        for (int i = 0; i < width; i++) begin
            out_insts[i].valid = i < int'(num_dispatch);   // low lanes first
            out_insts[i].dest  = ib_insts[i].word.r_form.dest;
            out_insts[i].src1  = ib_insts[i].word.r_form.src1;
            if (ib_insts[i].word.i_form.opcode[3]) begin  // immediate form
                out_insts[i].src2      = '0;
                out_insts[i].uses_src2 = 1'b0;
                out_insts[i].imm       = ib_insts[i].word.i_form.imm;
            end else begin
                out_insts[i].src2      = ib_insts[i].word.r_form.src2;
                out_insts[i].uses_src2 = 1'b1;
                out_insts[i].imm       = '0;
            end
            out_pc[i] = ib_insts[i].pc;
        end
    end

endmodule

`default_nettype wire

/* logic/inst_buffer.sv */
// circular instruction buffer between the fetch stand-in and dispatch
// stamps each accepted word with the running fetch pc
`default_nettype none

module inst_buffer (
    input  logic                                          clock,
    input  logic                                          reset,
    input  rename_pkg::inst_packet_t [rename_pkg::width-1:0] in_insts,
    input  rename_pkg::count_t                            num_input,
    input  rename_pkg::count_t                            num_dispatch,
    output rename_pkg::inst_packet_t [rename_pkg::width-1:0] ib_insts,
    output logic [3:0]                                    ib_count,
    output logic [3:0]                                    open_entries,
    output rename_pkg::addr_t                             pc
);
    import rename_pkg::*;

    inst_packet_t [ib_depth-1:0] mem;   // payload, no reset
    ib_ptr_t                     head;  // oldest entry
    ib_ptr_t                     tail;  // next free slot
    logic [3:0]                  count;

    assign ib_count     = count;
    assign open_entries = 4'(ib_depth) - count;

    // two oldest entries go to dispatch, lanes past count are ignored there
    always_comb begin
        for (int i = 0; i < width; i++) begin
            ib_insts[i] = mem[head + ib_ptr_t'(i)];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            pc    <= '0;
        end else begin
            head  <= head + ib_ptr_t'(num_dispatch);
            tail  <= tail + ib_ptr_t'(num_input);
            count <= count + 4'(num_input) - 4'(num_dispatch);
            pc    <= pc + (addr_t'(num_input) << 2);   // 4 bytes per word
        end
    end

    // accepted words, lane 0 first
    always_ff @(posedge clock) begin
        for (int i = 0; i < width; i++) begin
            if (!reset && i < int'(num_input)) begin
                mem[tail + ib_ptr_t'(i)].word <= in_insts[i].word;
                mem[tail + ib_ptr_t'(i)].pc   <= pc + addr_t'(4 * i);
            end
        end
    end

    ////////////////////////////////////////////////////
    // protocol checks
    a_no_overfill: assert property (@(posedge clock) disable iff (reset)
        4'(num_input) <= open_entries);
    a_no_overdrain: assert property (@(posedge clock) disable iff (reset)
        4'(num_dispatch) <= ib_count);

endmodule

`default_nettype wire

/* project.f */
common/rename_pkg.sv
logic/inst_buffer.sv
logic/dispatch.sv
rename/free_list.sv
rename/map_table.sv
rob/rob.sv
logic/cpu_front.sv
test/tb_checker.sv
test/tb_top.sv

/* rename/free_list.sv */
// fifo of free physical tags
// pops at dispatch, pushes the t_old of retiring instructions
`default_nettype none

module free_list (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rename_pkg::count_t                        rd_num,
    input  rename_pkg::count_t                        wr_num,
    input  rename_pkg::phys_idx_t [rename_pkg::width-1:0] wr_reg,
    output rename_pkg::phys_idx_t [rename_pkg::width-1:0] rd_reg,
    output logic [3:0]                                avail
);
    import rename_pkg::*;

    phys_idx_t [fl_depth-1:0] mem;
    fl_ptr_t                  head;   // next tag handed out
    fl_ptr_t                  tail;   // next slot for a freed tag
    logic [3:0]               count;

    assign avail = count;   // before this cycle's pushes

    always_comb begin
        for (int i = 0; i < width; i++) begin
            rd_reg[i] = mem[head + fl_ptr_t'(i)];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= 4'(fl_depth);
            // tags above the arch range start free, in order
            for (int i = 0; i < fl_depth; i++) begin
                mem[i] <= phys_idx_t'(arch_regs + i);
            end
        end else begin
            head  <= head + fl_ptr_t'(rd_num);
            tail  <= tail + fl_ptr_t'(wr_num);
            count <= count + 4'(wr_num) - 4'(rd_num);
            for (int i = 0; i < width; i++) begin
                if (i < int'(wr_num)) mem[tail + fl_ptr_t'(i)] <= wr_reg[i];
            end
        end
    end

    ////////////////////////////////////////////////////
    // a tag leaves and returns exactly once
    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        4'(rd_num) <= count);
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        5'(count) + 5'(wr_num) <= 5'(fl_depth) + 5'(rd_num));

endmodule

`default_nettype wire

/* rename/map_table.sv */
// arch to phys rename map
// lookups bypass older lanes of the same dispatch group
`default_nettype none

module map_table (
    input  logic                                            clock,
    input  logic                                            reset,
    input  rename_pkg::decoded_packet_t [rename_pkg::width-1:0] dis_insts,
    input  rename_pkg::phys_idx_t       [rename_pkg::width-1:0] free_reg,
    output rename_pkg::phys_idx_t       [rename_pkg::width-1:0] r1_p,
    output rename_pkg::phys_idx_t       [rename_pkg::width-1:0] r2_p,
    output rename_pkg::phys_idx_t       [rename_pkg::width-1:0] t_old
);
    import rename_pkg::*;

    phys_idx_t [arch_regs-1:0] map;

    always_comb begin
        for (int i = 0; i < width; i++) begin
            r1_p[i]  = map[dis_insts[i].src1];
            r2_p[i]  = map[dis_insts[i].src2];
            t_old[i] = map[dis_insts[i].dest];
            // older lanes in ascending order, so the youngest writer wins
            for (int j = 0; j < i; j++) begin
                if (dis_insts[j].valid) begin
                    if (dis_insts[i].src1 == dis_insts[j].dest) r1_p[i]  = free_reg[j];
                    if (dis_insts[i].src2 == dis_insts[j].dest) r2_p[i]  = free_reg[j];
                    if (dis_insts[i].dest == dis_insts[j].dest) t_old[i] = free_reg[j];
                end
            end
            if (!dis_insts[i].uses_src2) r2_p[i] = '0;   // no second source
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_regs; i++) begin
                map[i] <= phys_idx_t'(i);   // identity map
            end
        end else begin
            for (int i = 0; i < width; i++) begin
                if (dis_insts[i].valid) map[dis_insts[i].dest] <= free_reg[i];
            end
        end
    end

    // bypass above assumes valid lanes are packed from lane 0
    a_lanes_packed: assert property (@(posedge clock) disable iff (reset)
        dis_insts[1].valid |-> dis_insts[0].valid);

endmodule

`default_nettype wire

/* rob/rob.sv */
// reorder buffer, in program order
// completion marks entries by tag, up to two done entries retire per cycle
`default_nettype none

module rob (
    input  logic                                            clock,
    input  logic                                            reset,
    input  rename_pkg::decoded_packet_t [rename_pkg::width-1:0] wr_insts,
    input  rename_pkg::addr_t           [rename_pkg::width-1:0] wr_pc,
    input  rename_pkg::count_t                              num_accept,
    input  rename_pkg::phys_idx_t       [rename_pkg::width-1:0] t,
    input  rename_pkg::phys_idx_t       [rename_pkg::width-1:0] t_old,
    input  rename_pkg::phys_idx_t       [rename_pkg::width-1:0] t1,
    input  rename_pkg::phys_idx_t       [rename_pkg::width-1:0] t2,
    input  logic                        [rename_pkg::width-1:0] complete_valid,
    input  rename_pkg::phys_idx_t       [rename_pkg::width-1:0] complete_t,
    output rename_pkg::commit_packet_t  [rename_pkg::width-1:0] retiring,
    output rename_pkg::count_t                              num_retired,
    output logic [3:0]                                      open_entries
);
    import rename_pkg::*;

    commit_packet_t [rob_depth-1:0] entries;   // payload only
    logic           [rob_depth-1:0] live;      // slot holds an instruction
    logic           [rob_depth-1:0] done;      // completed, waiting to retire
    rob_ptr_t                       head;
    rob_ptr_t                       tail;
    rob_ptr_t                       head_next;
    logic [3:0]                     count;
    logic                           ret0;
    logic                           ret1;

    assign open_entries = 4'(rob_depth) - count;   // before retirement
    assign head_next    = head + rob_ptr_t'(1);

    ////////////////////////////////////////////////////
    // retire, combinational from state
    always_comb begin
        ret0 = live[head] && done[head];
        ret1 = ret0 && live[head_next] && done[head_next];   // only behind the head
        num_retired       = count_t'(ret0) + count_t'(ret1);
        retiring[0]       = entries[head];
        retiring[0].valid = ret0;
        retiring[1]       = entries[head_next];
        retiring[1].valid = ret1;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            live  <= '0;
            done  <= '0;
        end else begin
            // completion cam, stray tags match nothing
            for (int k = 0; k < rob_depth; k++) begin
                for (int c = 0; c < width; c++) begin
                    if (complete_valid[c] && live[k] && entries[k].t == complete_t[c])
                        done[k] <= 1'b1;
                end
            end
            if (ret0) live[head] <= 1'b0;
            if (ret1) live[head_next] <= 1'b0;
            for (int i = 0; i < width; i++) begin
                if (wr_insts[i].valid) begin
                    live[tail + rob_ptr_t'(i)] <= 1'b1;
                    done[tail + rob_ptr_t'(i)] <= 1'b0;
                end
            end
            head  <= head + rob_ptr_t'(num_retired);
            tail  <= tail + rob_ptr_t'(num_accept);
            count <= count + 4'(num_accept) - 4'(num_retired);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < width; i++) begin
            if (wr_insts[i].valid) begin
                entries[tail + rob_ptr_t'(i)] <= '{valid: 1'b1, pc: wr_pc[i],
                    dest: wr_insts[i].dest, t: t[i], t_old: t_old[i], t1: t1[i],
                    t2: t2[i], uses_src2: wr_insts[i].uses_src2};
            end
        end
    end

    a_no_overfill: assert property (@(posedge clock) disable iff (reset)
        4'(num_accept) <= open_entries);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_top \
    -f project.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "^TB PASSED$" && exit 0 || exit 1

/* test/tb_checker.sv */
// commit checker for the rename front end
// records accepted words in program order and renames them in a model at commit
`default_nettype none

module tb_checker (
    input  logic                                             clock,
    input  logic                                             reset,
    input  rename_pkg::inst_packet_t   [rename_pkg::width-1:0] in_insts,
    input  rename_pkg::count_t                               num_input,
    input  logic                       [rename_pkg::width-1:0] complete_valid,
    input  rename_pkg::phys_idx_t      [rename_pkg::width-1:0] complete_t,
    input  rename_pkg::commit_packet_t [rename_pkg::width-1:0] committed_insts,
    input  logic [3:0]                                       ib_open,
    input  rename_pkg::addr_t                                pc,
    input  logic                                             check_full,
    output int                                               n_accepted,
    output int                                               n_committed,
    output int                                               n_errors
);
    timeunit 1ns;
    timeprecision 100ps;
    import rename_pkg::*;

    logic [15:0] words[$];          // accepted, oldest first
    int          accept_cycle[$];   // cycle each word was taken
    phys_idx_t   model_map[arch_regs];
    phys_idx_t   model_free[$];     // 8 .. 15, then t_old in commit order
    int          last_done[phys_regs];
    int          cycle;
    logic        after_reset;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("** Error: %s is %h, expected %h (commit %0d, %0t)",
                name, got, want, n_committed, $time);
            n_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        n_errors++;
    endtask

    ////////////////////////////////////////////////////
    // rename the next program-order word and compare one commit lane
    task automatic check_commit(input int lane, input commit_packet_t c);
        logic [15:0] w;
        int          acc;
        arch_idx_t   dest;
        arch_idx_t   src1;
        arch_idx_t   src2;
        logic        imm_form;
        phys_idx_t   exp_t;
        phys_idx_t   exp_t1;
        phys_idx_t   exp_t2;
        phys_idx_t   exp_t_old;
        string       lp;
        lp = $sformatf("committed_insts[%0d]", lane);
        if (words.size() == 0) begin
            report_failure($sformatf("lane %0d committed with nothing outstanding", lane));
            return;
        end
        w        = words.pop_front();
        acc      = accept_cycle.pop_front();
        imm_form = w[15];       // opcode bit 3
        dest     = w[11:9];
        src1     = w[8:6];
        src2     = w[5:3];
        exp_t     = model_free.pop_front();
        exp_t1    = model_map[src1];
        exp_t2    = imm_form ? phys_idx_t'(0) : model_map[src2];
        exp_t_old = model_map[dest];
        model_map[dest] = exp_t;   // sources read before the own write
        compare_field({lp, ".pc"}, c.pc, 32'(4 * n_committed));
        compare_field({lp, ".dest"}, 32'(c.dest), 32'(dest));
        compare_field({lp, ".t"}, 32'(c.t), 32'(exp_t));
        compare_field({lp, ".t_old"}, 32'(c.t_old), 32'(exp_t_old));
        compare_field({lp, ".t1"}, 32'(c.t1), 32'(exp_t1));
        compare_field({lp, ".t2"}, 32'(c.t2), 32'(exp_t2));
        compare_field({lp, ".uses_src2"}, 32'(c.uses_src2), 32'(!imm_form));
        // earliest useful completion is two edges after acceptance
        if (last_done[exp_t] < acc + 2) begin
            report_failure($sformatf("tag %h committed without a completion after dispatch",
                exp_t));
        end
        model_free.push_back(exp_t_old);
        n_committed++;
    endtask

    // falling edge, inputs and commit lanes are stable here
    always @(negedge clock) begin
        if (reset) begin
            words.delete();
            accept_cycle.delete();
            model_free.delete();
            for (int r = 0; r < arch_regs; r++) begin
                model_map[r] = phys_idx_t'(r);        // identity
            end
            for (int r = arch_regs; r < phys_regs; r++) begin
                model_free.push_back(phys_idx_t'(r));
            end
            for (int r = 0; r < phys_regs; r++) begin
                last_done[r] = -1;
            end
            n_accepted  = 0;
            n_committed = 0;
            n_errors    = 0;
            cycle       = 0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                compare_field("ib_open", 32'(ib_open), 32'(ib_depth));
                for (int i = 0; i < width; i++) begin
                    compare_field($sformatf("committed_insts[%0d].valid", i),
                        32'(committed_insts[i].valid), 32'd0);
                end
                after_reset = 1'b0;
            end
            compare_field("pc", pc, 32'(4 * n_accepted));
            if (committed_insts[1].valid && !committed_insts[0].valid) begin
                report_failure("commit lane 1 valid while lane 0 is not");
            end
            for (int i = 0; i < width; i++) begin
                if (committed_insts[i].valid) check_commit(i, committed_insts[i]);
            end
            if (check_full) begin    // completion has been off for a while
                compare_field("ib_open", 32'(ib_open), 32'd0);
                if (n_accepted - n_committed != ib_depth + rob_depth) begin
                    report_failure($sformatf("%0d in flight with completion off, not %0d",
                        n_accepted - n_committed, ib_depth + rob_depth));
                end
            end
            if (n_accepted - n_committed > ib_depth + rob_depth) begin
                report_failure("more instructions in flight than buffer and rob can hold");
            end
            for (int i = 0; i < width; i++) begin
                if (complete_valid[i]) last_done[complete_t[i]] = cycle;
            end
            for (int i = 0; i < int'(num_input); i++) begin
                words.push_back(16'(in_insts[i].word));   // lane 0 first
                accept_cycle.push_back(cycle);
                n_accepted++;
            end
            cycle++;
        end
    end

endmodule

`default_nettype wire

/* test/tb_top.sv */
// testbench top for the rename front end
// drives lfsr traffic and completions in phases, tb_checker compares every commit
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import rename_pkg::*;

    localparam int reset_cycles = 10;
    localparam int mixed_cycles = 300;
    localparam int quiet_cycles = 40;     // completion disabled
    localparam int drain_limit  = 1000;
    localparam int stall_limit  = 200;    // cycles without a commit

    logic                       clock;
    logic                       reset;
    inst_packet_t   [width-1:0] in_insts;
    count_t                     num_input;
    logic           [width-1:0] complete_valid;
    phys_idx_t      [width-1:0] complete_t;
    commit_packet_t [width-1:0] committed_insts;
    logic [3:0]                 ib_open;
    addr_t                      pc;
    logic                       check_full;      // pipeline must be full now
    int                         n_accepted;
    int                         n_committed;
    int                         n_errors;        // from the checker
    int                         run_errors;      // timeouts and stalls
    logic                       run_failed;
    int                         last_committed;
    int                         idle_cycles;
    logic [15:0]                lfsr;

    initial clock = 1'b0;
    always #50 clock = ~clock;   // 100 ns period

    cpu_front dut (
        .clock(clock), .reset(reset),
        .in_insts(in_insts), .num_input(num_input),
        .complete_valid(complete_valid), .complete_t(complete_t),
        .committed_insts(committed_insts), .ib_open(ib_open), .pc(pc)
    );

    tb_checker u_checker (
        .clock(clock), .reset(reset),
        .in_insts(in_insts), .num_input(num_input),
        .complete_valid(complete_valid), .complete_t(complete_t),
        .committed_insts(committed_insts), .ib_open(ib_open), .pc(pc),
        .check_full(check_full),
        .n_accepted(n_accepted), .n_committed(n_committed), .n_errors(n_errors)
    );

    ////////////////////////////////////////////////////
    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            lfsr_step = (s >> 1) ^ 16'hb400;
        end else begin
            lfsr_step = s >> 1;
        end
    endfunction

    // one step per bit taken
    task automatic draw_bits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[14:0], lfsr[0]};
        end
    endtask

    // one clock of stimulus plus the commit stall watch
    task automatic step(input logic comp_en, input logic inp_en);
        logic [15:0] bits;
        count_t      n;
        @(posedge clock);
        #1;
        check_full = 1'b0;
        draw_bits(2, bits);
        n = count_t'(bits[1:0]);
        if (n == 2'd3) n = 2'd2;                          // 0 .. width
        if (!inp_en) n = '0;
        if (4'(n) > ib_open) n = count_t'(ib_open);       // never past the open slots
        num_input = n;
        for (int i = 0; i < width; i++) begin
            draw_bits(16, bits);
            in_insts[i].word  = inst_word_u'(bits);
            in_insts[i].pc    = '0;                       // buffer stamps the pc
            draw_bits(5, bits);
            complete_valid[i] = comp_en & bits[4];
            complete_t[i]     = bits[3:0];                // stray tags too
        end
        if (n_committed != last_committed || !comp_en || n_committed == n_accepted) begin
            idle_cycles = 0;
        end else begin
            idle_cycles++;
        end
        last_committed = n_committed;
        if (idle_cycles > stall_limit) begin
            $display("commits stalled for %0d cycles with %0d instructions in flight",
                idle_cycles, n_accepted - n_committed);
            run_errors++;
            run_failed = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////
    // run phases
    initial begin
        lfsr           = 16'd56;
        reset          = 1'b1;
        num_input      = '0;
        in_insts       = '0;
        complete_valid = '0;
        complete_t     = '0;
        check_full     = 1'b0;
        run_errors     = 0;
        run_failed     = 1'b0;
        last_committed = 0;
        idle_cycles    = 0;
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clock);
        end
        #1 reset = 1'b0;

        for (int i = 0; i < mixed_cycles && !run_failed; i++) begin
            step(1'b1, 1'b1);   // out of order completion
        end
        for (int i = 0; i < quiet_cycles && !run_failed; i++) begin
            step(1'b0, 1'b1);   // rob and buffer fill up
        end
        check_full = 1'b1;      // sampled at the next falling edge
        for (int i = 0; i < mixed_cycles && !run_failed; i++) begin
            step(1'b1, 1'b1);
        end
        // no new input, everything in flight must commit
        for (int i = 0; i < drain_limit && !run_failed && n_committed != n_accepted; i++) begin
            step(1'b1, 1'b0);
        end
        if (!run_failed && n_committed != n_accepted) begin
            $display("drain timed out with %0d instructions still in flight",
                n_accepted - n_committed);
            run_errors++;
        end

        $display("summary: %0d accepted, %0d committed, %0d check errors, %0d run errors",
            n_accepted, n_committed, n_errors, run_errors);
        if (n_errors == 0 && run_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
